// ==== Makefile ====
SRC = build.f hdl/cpu_cfg.svh hdl/cpu_pkg.sv hdl/fetch.sv hdl/register_bank.sv \
      hdl/decode.sv hdl/execute.sv hdl/memory.sv hdl/cpu.sv sim/tb_clock.sv sim/cpu_tb.sv

.PHONY: all run check clean

all: check

obj_dir/Vcpu_tb: $(SRC)
	verilator --binary --timing --assert -f build.f --top-module cpu_tb -o Vcpu_tb

run: obj_dir/Vcpu_tb
	./obj_dir/Vcpu_tb > sim.log; cat sim.log
	grep -q "TESTBENCH PASSED" sim.log

check: run

clean:
	rm -rf obj_dir sim.log

// ==== build.f ====
+incdir+hdl
hdl/cpu_pkg.sv
hdl/fetch.sv
hdl/register_bank.sv
hdl/decode.sv
hdl/execute.sv
hdl/memory.sv
hdl/cpu.sv
sim/tb_clock.sv
sim/cpu_tb.sv

// ==== hdl/cpu.sv ====
`default_nettype none

`include "cpu_cfg.svh"

module cpu
    import cpu_pkg::*;
(
    input  logic                               clock,
    input  logic                               reset,
    input  logic                               enable,    // Global pipeline hold when low
    input  logic                               imem_write,
    input  logic [$clog2(`CPU_IMEM_DEPTH)-1:0] imem_address,
    input  logic [`CPU_XLEN-1:0]               imem_data,
    output logic                               retire_valid,
    output logic [4:0]                         retire_rd,
    output logic [`CPU_XLEN-1:0]               retire_value
);
    fe_de_t               fe_de;
    de_ex_t               de_ex;
    ex_mem_t              ex_mem;
    mem_wb_t              mem_wb;
    mem_wb_t              wb_commit;
    redirect_t            redirect;
    logic                 stall;
    logic [4:0]           rs1;
    logic [4:0]           rs2;
    logic [`CPU_XLEN-1:0] rs1_value;
    logic [`CPU_XLEN-1:0] rs2_value;

    fetch u_fetch (
        .clock, .reset, .enable, .stall, .redirect,
        .imem_write, .imem_address, .imem_data,
        .fe_de
    );

    decode u_decode (
        .clock, .reset, .enable,
        .fe_de, .redirect,
        .rs1, .rs2, .rs1_value, .rs2_value,
        .ex_rd_busy (ex_mem),
        .stall,
        .de_ex
    );

    execute u_execute (
        .clock, .reset, .enable,
        .de_ex, .redirect, .ex_mem
    );

    memory u_memory (
        .clock, .reset, .enable,
        .ex_mem, .mem_wb
    );

    // A held writeback record commits once, on the enabled edge
    always_comb begin
        wb_commit       = mem_wb;
        wb_commit.valid = mem_wb.valid && mem_wb.reg_write && enable;
    end

    register_bank u_register_bank (
        .clock, .reset,
        .rs1, .rs2, .rs1_value, .rs2_value,
        .wb (wb_commit)
    );

    assign retire_valid = wb_commit.valid;
    assign retire_rd    = wb_commit.rd;
    assign retire_value = wb_commit.value;

endmodule

`default_nettype wire

// ==== hdl/cpu_cfg.svh ====
`ifndef CPU_CFG_SVH
`define CPU_CFG_SVH

// Data path and address width
`define CPU_XLEN 32

// Instruction memory size in words
`define CPU_IMEM_DEPTH 256

// Data memory size in words
`define CPU_DMEM_DEPTH 256

// First fetch address out of reset
`define CPU_RESET_PC 32'h0000_0000

`endif

// ==== hdl/cpu_pkg.sv ====
`default_nettype none

`include "cpu_cfg.svh"

package cpu_pkg;

    // Major opcodes of the supported RV32I subset
    typedef enum logic [6:0] {
        OP_IMM    = 7'b0010011,
        OP_REG    = 7'b0110011,
        OP_LUI    = 7'b0110111,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_BRANCH = 7'b1100011,
        OP_JAL    = 7'b1101111
    } opcode_t;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B  // LUI takes the immediate as is
    } alu_op_t;

    typedef struct packed {
        logic                 valid;
        logic [`CPU_XLEN-1:0] pc;
        logic [`CPU_XLEN-1:0] instr;
    } fe_de_t;

    typedef struct packed {
        logic                 valid;
        logic [`CPU_XLEN-1:0] pc;
        logic [`CPU_XLEN-1:0] rs1_value;
        logic [`CPU_XLEN-1:0] rs2_value;
        logic [`CPU_XLEN-1:0] imm;
        alu_op_t              alu_op;
        logic                 alu_src_imm;
        logic                 branch;
        logic                 branch_ne;   // BNE when set, BEQ otherwise
        logic                 jump;
        logic                 mem_read;
        logic                 mem_write;
        logic                 reg_write;
        logic [4:0]           rd;
    } de_ex_t;

    typedef struct packed {
        logic                 valid;
        logic [`CPU_XLEN-1:0] result;      // ALU result, link value or address
        logic [`CPU_XLEN-1:0] store_data;
        logic                 mem_read;
        logic                 mem_write;
        logic                 reg_write;
        logic [4:0]           rd;
    } ex_mem_t;

    typedef struct packed {
        logic                 valid;
        logic                 reg_write;
        logic [4:0]           rd;
        logic [`CPU_XLEN-1:0] value;
    } mem_wb_t;

    typedef struct packed {
        logic                 taken;
        logic [`CPU_XLEN-1:0] target;
    } redirect_t;

endpackage

`default_nettype wire

// ==== hdl/decode.sv ====
`default_nettype none

`include "cpu_cfg.svh"

module decode
    import cpu_pkg::*;
(
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 enable,
    input  fe_de_t               fe_de,
    input  redirect_t            redirect,
    output logic [4:0]           rs1,
    output logic [4:0]           rs2,
    input  logic [`CPU_XLEN-1:0] rs1_value,
    input  logic [`CPU_XLEN-1:0] rs2_value,
    input  ex_mem_t              ex_rd_busy,
    output logic                 stall,
    output de_ex_t               de_ex
);
    logic [31:0] instr;
    logic [2:0]  funct3;
    logic        known;
    logic        use_rs1;
    logic        use_rs2;
    logic        hit_ex;
    logic        hit_mem;
    logic        issue;
    de_ex_t      ctrl;

    assign instr  = fe_de.instr;
    assign funct3 = instr[14:12];
    assign rs1    = instr[19:15];
    assign rs2    = instr[24:20];

    always_comb begin
        ctrl           = '0;
        ctrl.pc        = fe_de.pc;
        ctrl.rs1_value = rs1_value;
        ctrl.rs2_value = rs2_value;
        ctrl.rd        = instr[11:7];
        known          = 1'b1;
        use_rs1        = 1'b0;
        use_rs2        = 1'b0;
        case (instr[6:0])
            OP_IMM: begin  // ADDI only
                ctrl.imm         = {{20{instr[31]}}, instr[31:20]};
                ctrl.alu_op      = ALU_ADD;
                ctrl.alu_src_imm = 1'b1;
                ctrl.reg_write   = 1'b1;
                use_rs1          = 1'b1;
                known            = (funct3 == 3'b000);
            end
            OP_REG: begin
                ctrl.reg_write = 1'b1;
                use_rs1        = 1'b1;
                use_rs2        = 1'b1;
                case ({instr[31:25], funct3})
                    {7'b0000000, 3'b000}: ctrl.alu_op = ALU_ADD;
                    {7'b0100000, 3'b000}: ctrl.alu_op = ALU_SUB;
                    {7'b0000000, 3'b111}: ctrl.alu_op = ALU_AND;
                    {7'b0000000, 3'b110}: ctrl.alu_op = ALU_OR;
                    {7'b0000000, 3'b100}: ctrl.alu_op = ALU_XOR;
                    {7'b0000000, 3'b010}: ctrl.alu_op = ALU_SLT;
                    default:              known       = 1'b0;
                endcase
            end
            OP_LUI: begin
                ctrl.imm         = {instr[31:12], 12'b0};
                ctrl.alu_op      = ALU_PASS_B;
                ctrl.alu_src_imm = 1'b1;
                ctrl.reg_write   = 1'b1;
            end
            OP_LOAD: begin  // LW
                ctrl.imm         = {{20{instr[31]}}, instr[31:20]};
                ctrl.alu_src_imm = 1'b1;
                ctrl.mem_read    = 1'b1;
                ctrl.reg_write   = 1'b1;
                use_rs1          = 1'b1;
                known            = (funct3 == 3'b010);
            end
            OP_STORE: begin  // SW
                ctrl.imm         = {{20{instr[31]}}, instr[31:25], instr[11:7]};
                ctrl.alu_src_imm = 1'b1;
                ctrl.mem_write   = 1'b1;
                use_rs1          = 1'b1;
                use_rs2          = 1'b1;
                known            = (funct3 == 3'b010);
            end
            OP_BRANCH: begin
                ctrl.imm       = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                                  instr[11:8], 1'b0};
                ctrl.branch    = 1'b1;
                ctrl.branch_ne = funct3[0];
                use_rs1        = 1'b1;
                use_rs2        = 1'b1;
                known          = (funct3[2:1] == 2'b00);  // BEQ or BNE
            end
            OP_JAL: begin
                ctrl.imm       = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                                  instr[30:21], 1'b0};
                ctrl.jump      = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            default: known = 1'b0;
        endcase
    end

    // Producers still ahead of writeback, x0 never counts
    assign hit_ex  = de_ex.valid && de_ex.reg_write && (de_ex.rd != 5'd0);
    assign hit_mem = ex_rd_busy.valid && ex_rd_busy.reg_write && (ex_rd_busy.rd != 5'd0);

    assign stall = fe_de.valid && (
        (use_rs1 && ((hit_ex && rs1 == de_ex.rd) || (hit_mem && rs1 == ex_rd_busy.rd))) ||
        (use_rs2 && ((hit_ex && rs2 == de_ex.rd) || (hit_mem && rs2 == ex_rd_busy.rd))));

    assign issue = fe_de.valid && known && !stall && !redirect.taken;

    always_ff @(posedge clock) begin
        if (reset) begin
            de_ex.valid <= 1'b0;
        end else if (enable) begin
            de_ex       <= ctrl;
            de_ex.valid <= issue;  // Bubble on stall, flush or bad opcode
        end
    end

endmodule

`default_nettype wire

// ==== hdl/execute.sv ====
`default_nettype none

`include "cpu_cfg.svh"

module execute
    import cpu_pkg::*;
(
    input  logic      clock,
    input  logic      reset,
    input  logic      enable,
    input  de_ex_t    de_ex,
    output redirect_t redirect,
    output ex_mem_t   ex_mem
);
    logic [`CPU_XLEN-1:0] operand_b;
    logic [`CPU_XLEN-1:0] alu_result;
    logic                 equal;
    logic                 branch_hit;

    assign operand_b = de_ex.alu_src_imm ? de_ex.imm : de_ex.rs2_value;

    always_comb begin
        case (de_ex.alu_op)
            ALU_ADD:    alu_result = de_ex.rs1_value + operand_b;
            ALU_SUB:    alu_result = de_ex.rs1_value - operand_b;
            ALU_AND:    alu_result = de_ex.rs1_value & operand_b;
            ALU_OR:     alu_result = de_ex.rs1_value | operand_b;
            ALU_XOR:    alu_result = de_ex.rs1_value ^ operand_b;
            ALU_SLT: begin
                alu_result = `CPU_XLEN'($signed(de_ex.rs1_value) < $signed(operand_b));
            end
            ALU_PASS_B: alu_result = operand_b;
            default:    alu_result = '0;
        endcase
    end

    // Branch decision and target, resolved here so two younger slots get flushed
    assign equal           = (de_ex.rs1_value == de_ex.rs2_value);
    assign branch_hit      = de_ex.branch && (equal ^ de_ex.branch_ne);
    assign redirect.taken  = de_ex.valid && (de_ex.jump || branch_hit);
    assign redirect.target = de_ex.pc + de_ex.imm;

    always_ff @(posedge clock) begin
        if (reset) begin
            ex_mem.valid <= 1'b0;
        end else if (enable) begin
            ex_mem.valid      <= de_ex.valid;
            ex_mem.result     <= de_ex.jump ? de_ex.pc + `CPU_XLEN'(4) : alu_result;
            ex_mem.store_data <= de_ex.rs2_value;
            ex_mem.mem_read   <= de_ex.mem_read;
            ex_mem.mem_write  <= de_ex.mem_write;
            ex_mem.reg_write  <= de_ex.reg_write;
            ex_mem.rd         <= de_ex.rd;
        end
    end

    // Redirects come only from a branch or a jump, never from a memory access
    taken_needs_control: assert property (@(posedge clock) disable iff (reset)
        redirect.taken |-> (!de_ex.mem_read && !de_ex.mem_write &&
                            de_ex.reg_write == de_ex.jump));

endmodule

`default_nettype wire

// ==== hdl/fetch.sv ====
`default_nettype none

`include "cpu_cfg.svh"

module fetch
    import cpu_pkg::*;
(
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                enable,
    input  logic                                stall,
    input  redirect_t                           redirect,
    input  logic                                imem_write,
    input  logic [$clog2(`CPU_IMEM_DEPTH)-1:0]  imem_address,
    input  logic [`CPU_XLEN-1:0]                imem_data,
    output fe_de_t                              fe_de
);
    localparam int IMEM_AW = $clog2(`CPU_IMEM_DEPTH);

    logic [`CPU_XLEN-1:0] imem [`CPU_IMEM_DEPTH];
    logic [`CPU_XLEN-1:0] pc;

    // Program load, independent of the pipeline hold
    always_ff @(posedge clock) begin
        if (imem_write) begin
            imem[imem_address] <= imem_data;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pc <= `CPU_RESET_PC;
        end else if (enable) begin
            if (redirect.taken) begin
                pc <= redirect.target;
            end else if (!stall) begin
                pc <= pc + `CPU_XLEN'(4);
            end
        end
    end

    // Synchronous ROM read, so the record trails its PC by one cycle
    always_ff @(posedge clock) begin
        if (reset) begin
            fe_de.valid <= 1'b0;
        end else if (enable) begin
            if (redirect.taken) begin
                fe_de.valid <= 1'b0;  // Kill the word fetched behind the branch
            end else if (!stall) begin
                fe_de.valid <= 1'b1;
                fe_de.pc    <= pc;
                fe_de.instr <= imem[pc[IMEM_AW+1:2]];
            end
        end
    end

    pc_aligned: assert property (@(posedge clock) disable iff (reset) pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// ==== hdl/memory.sv ====
`default_nettype none

`include "cpu_cfg.svh"

module memory
    import cpu_pkg::*;
(
    input  logic    clock,
    input  logic    reset,
    input  logic    enable,
    input  ex_mem_t ex_mem,
    output mem_wb_t mem_wb
);
    localparam int DMEM_AW = $clog2(`CPU_DMEM_DEPTH);

    logic [`CPU_XLEN-1:0] dmem [`CPU_DMEM_DEPTH];
    logic [DMEM_AW-1:0]   word_index;
    logic                 store;

    assign word_index = ex_mem.result[DMEM_AW+1:2];  // Word access only
    assign store      = enable && ex_mem.valid && ex_mem.mem_write;

    always_ff @(posedge clock) begin
        if (store) begin
            dmem[word_index] <= ex_mem.store_data;
        end
    end

    // RAM read lands directly in the writeback record
    always_ff @(posedge clock) begin
        if (reset) begin
            mem_wb.valid <= 1'b0;
        end else if (enable) begin
            mem_wb.valid     <= ex_mem.valid;
            mem_wb.reg_write <= ex_mem.reg_write;
            mem_wb.rd        <= ex_mem.rd;
            if (ex_mem.mem_read) begin
                mem_wb.value <= dmem[word_index];
            end else begin
                mem_wb.value <= ex_mem.result;
            end
        end
    end

    load_store_exclusive: assert property (@(posedge clock) disable iff (reset)
        ex_mem.valid |-> !(ex_mem.mem_read && ex_mem.mem_write));

endmodule

`default_nettype wire

// ==== hdl/register_bank.sv ====
`default_nettype none

`include "cpu_cfg.svh"

module register_bank
    import cpu_pkg::*;
(
    input  logic                 clock,
    input  logic                 reset,
    input  logic [4:0]           rs1,
    input  logic [4:0]           rs2,
    output logic [`CPU_XLEN-1:0] rs1_value,
    output logic [`CPU_XLEN-1:0] rs2_value,
    input  mem_wb_t              wb
);
    logic [`CPU_XLEN-1:0] regs [1:31];  // No storage behind x0
    logic                 wb_live;

    assign wb_live = wb.valid && wb.reg_write && (wb.rd != 5'd0);

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_live) begin
            regs[wb.rd] <= wb.value;
        end
    end

    // Same-cycle writeback is passed straight to the reader
    function automatic logic [`CPU_XLEN-1:0] read_port(input logic [4:0] index);
        if (index == 5'd0) begin
            return '0;
        end
        if (wb_live && (wb.rd == index)) begin
            return wb.value;
        end
        return regs[index];
    endfunction

    assign rs1_value = read_port(rs1);
    assign rs2_value = read_port(rs2);

    // A write aimed at x0 leaves every value under a read port where it was
    x0_stays_zero: assert property (@(posedge clock) disable iff (reset)
        (wb.valid && wb.reg_write && wb.rd == 5'd0) |=>
            (wb_live || ((!$stable(rs1) || $stable(rs1_value)) &&
                         (!$stable(rs2) || $stable(rs2_value)))));

endmodule

`default_nettype wire

// ==== sim/cpu_tb.sv ====
`default_nettype none

`include "cpu_cfg.svh"

module cpu_tb;
    localparam int MAX_CASES  = 8;
    localparam int MAX_WORDS  = 12;   // Also the bound on retires per case
    localparam int WAIT_LIMIT = 200;
    localparam int DRAIN      = 8;
    localparam int IMEM_AW    = $clog2(`CPU_IMEM_DEPTH);

    // {funct7, funct3} of the register-register ops
    localparam logic [9:0] F_ADD = 10'b0000000_000;
    localparam logic [9:0] F_SUB = 10'b0100000_000;
    localparam logic [9:0] F_AND = 10'b0000000_111;
    localparam logic [9:0] F_OR  = 10'b0000000_110;
    localparam logic [9:0] F_XOR = 10'b0000000_100;
    localparam logic [9:0] F_SLT = 10'b0000000_010;

    logic                 clock;
    logic                 reset;
    logic                 enable;
    logic                 imem_write;
    logic [IMEM_AW-1:0]   imem_address;
    logic [`CPU_XLEN-1:0] imem_data;
    logic                 retire_valid;
    logic [4:0]           retire_rd;
    logic [`CPU_XLEN-1:0] retire_value;

    string       case_name    [MAX_CASES];
    logic [31:0] program_word [MAX_CASES][MAX_WORDS];
    int          word_count   [MAX_CASES];
    logic [4:0]  expect_rd    [MAX_CASES][MAX_WORDS];
    logic [31:0] expect_value [MAX_CASES][MAX_WORDS];
    int          retire_count [MAX_CASES];
    int          hold_start   [MAX_CASES];  // Cycles after enable rises
    int          hold_length  [MAX_CASES];  // Zero means no hold
    int          case_total;
    int          failures;
    int          checked;

    tb_clock #(.PERIOD(100)) i_clock (.clock);

    cpu i_dut (
        .clock, .reset, .enable,
        .imem_write, .imem_address, .imem_data,
        .retire_valid, .retire_rd, .retire_value
    );

    // RV32I encoders
    function automatic logic [31:0] addi_instr(input int rd, input int rs1, input int imm);
        logic [31:0] i;
        i = imm;
        return {i[11:0], 5'(rs1), 3'b000, 5'(rd), 7'b0010011};
    endfunction

    function automatic logic [31:0] reg_op(input logic [9:0] funct, input int rd,
                                           input int rs1, input int rs2);
        return {funct[9:3], 5'(rs2), 5'(rs1), funct[2:0], 5'(rd), 7'b0110011};
    endfunction

    function automatic logic [31:0] lui_instr(input int rd, input int imm20);
        logic [31:0] i;
        i = imm20;
        return {i[19:0], 5'(rd), 7'b0110111};
    endfunction

    function automatic logic [31:0] load_instr(input int rd, input int rs1, input int imm);
        logic [31:0] i;
        i = imm;
        return {i[11:0], 5'(rs1), 3'b010, 5'(rd), 7'b0000011};
    endfunction

    function automatic logic [31:0] store_instr(input int rs2, input int rs1, input int imm);
        logic [31:0] i;
        i = imm;
        return {i[11:5], 5'(rs2), 5'(rs1), 3'b010, i[4:0], 7'b0100011};
    endfunction

    function automatic logic [31:0] branch_instr(input logic bne, input int rs1, input int rs2,
                                                 input int offset);
        logic [31:0] o;
        o = offset;
        return {o[12], o[10:5], 5'(rs2), 5'(rs1), {2'b00, bne}, o[4:1], o[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] jal_instr(input int rd, input int offset);
        logic [31:0] o;
        o = offset;
        return {o[20], o[10:1], o[11], o[19:12], 5'(rd), 7'b1101111};
    endfunction

    task automatic new_case(input string name, input int hold_at, input int hold_len);
        case_name[case_total]    = name;
        word_count[case_total]   = 0;
        retire_count[case_total] = 0;
        hold_start[case_total]   = hold_at;
        hold_length[case_total]  = hold_len;
        case_total++;
    endtask

    task automatic emit(input logic [31:0] word);
        program_word[case_total-1][word_count[case_total-1]] = word;
        word_count[case_total-1]++;
    endtask

    task automatic retires(input int rd, input logic [31:0] value);
        expect_rd[case_total-1][retire_count[case_total-1]]    = 5'(rd);
        expect_value[case_total-1][retire_count[case_total-1]] = value;
        retire_count[case_total-1]++;
    endtask

    task automatic build_table();
        new_case("alu_ops", 0, 0);
        emit(addi_instr(1, 0, 12));         retires(1, 32'd12);
        emit(addi_instr(2, 0, -5));         retires(2, 32'hffff_fffb);
        emit(reg_op(F_ADD, 3, 1, 2));       retires(3, 32'd7);
        emit(reg_op(F_SUB, 4, 1, 2));       retires(4, 32'd17);
        emit(reg_op(F_AND, 5, 1, 2));       retires(5, 32'd8);
        emit(reg_op(F_OR, 6, 1, 2));        retires(6, 32'hffff_ffff);
        emit(reg_op(F_XOR, 7, 1, 2));       retires(7, 32'hffff_fff7);
        emit(reg_op(F_SLT, 8, 2, 1));       retires(8, 32'd1);  // -5 < 12
        emit(reg_op(F_SLT, 9, 1, 2));       retires(9, 32'd0);
        emit(lui_instr(10, 'h12345));       retires(10, 32'h1234_5000);

        new_case("dependent_chain", 0, 0);
        emit(addi_instr(1, 0, 1));          retires(1, 32'd1);
        emit(reg_op(F_ADD, 2, 1, 1));       retires(2, 32'd2);
        emit(reg_op(F_ADD, 3, 2, 1));       retires(3, 32'd3);
        emit(reg_op(F_ADD, 4, 3, 2));       retires(4, 32'd5);
        emit(reg_op(F_SUB, 5, 4, 3));       retires(5, 32'd2);
        emit(addi_instr(5, 5, 100));        retires(5, 32'd102);
        emit(reg_op(F_XOR, 6, 5, 4));       retires(6, 32'd99);
        emit(lui_instr(7, 1));              retires(7, 32'h0000_1000);
        emit(reg_op(F_ADD, 7, 7, 6));       retires(7, 32'h0000_1063);

        new_case("load_store", 0, 0);
        emit(addi_instr(1, 0, 'h40));       retires(1, 32'h40);
        emit(addi_instr(2, 0, 'h123));      retires(2, 32'h123);
        emit(addi_instr(3, 0, -1));         retires(3, 32'hffff_ffff);
        emit(store_instr(2, 1, 0));         // sw x2, 0(x1)
        emit(store_instr(3, 1, 4));         // sw x3, 4(x1)
        emit(load_instr(4, 1, 0));          retires(4, 32'h123);
        emit(load_instr(5, 1, 4));          retires(5, 32'hffff_ffff);
        emit(reg_op(F_ADD, 6, 4, 5));       retires(6, 32'h122);

        new_case("branch_taken", 0, 0);
        emit(addi_instr(1, 0, 3));          retires(1, 32'd3);
        emit(addi_instr(2, 0, 3));          retires(2, 32'd3);
        emit(branch_instr(1'b0, 1, 2, 12)); // beq to pc 20
        emit(addi_instr(3, 0, 1));
        emit(addi_instr(4, 0, 2));
        emit(addi_instr(5, 0, 5));          retires(5, 32'd5);
        emit(branch_instr(1'b1, 1, 5, 12)); // bne to pc 36
        emit(addi_instr(6, 0, 6));
        emit(addi_instr(7, 0, 7));
        emit(addi_instr(8, 0, 8));          retires(8, 32'd8);

        new_case("branch_not_taken", 0, 0);
        emit(addi_instr(1, 0, 4));          retires(1, 32'd4);
        emit(addi_instr(2, 0, 9));          retires(2, 32'd9);
        emit(branch_instr(1'b0, 1, 2, 12));
        emit(addi_instr(3, 0, 1));          retires(3, 32'd1);
        emit(branch_instr(1'b1, 1, 1, 12));
        emit(addi_instr(4, 0, 2));          retires(4, 32'd2);
        emit(addi_instr(5, 0, 3));          retires(5, 32'd3);

        new_case("jal_link", 0, 0);
        emit(addi_instr(1, 0, 1));          retires(1, 32'd1);
        emit(jal_instr(2, 12));             retires(2, 32'd8);   // Link is pc 4 plus 4
        emit(addi_instr(3, 0, 3));
        emit(addi_instr(4, 0, 4));
        emit(addi_instr(5, 2, 2));          retires(5, 32'd10);
        emit(jal_instr(6, 8));              retires(6, 32'd24);
        emit(addi_instr(7, 0, 7));
        emit(addi_instr(8, 6, 1));          retires(8, 32'd25);

        new_case("x0_write", 0, 0);
        emit(addi_instr(0, 0, 55));         retires(0, 32'd55);
        emit(addi_instr(1, 0, 7));          retires(1, 32'd7);
        emit(reg_op(F_ADD, 2, 0, 0));       retires(2, 32'd0);
        emit(lui_instr(0, 'habcde));        retires(0, 32'habcd_e000);
        emit(reg_op(F_OR, 3, 0, 1));        retires(3, 32'd7);

        // Hold starts while the first write sits in writeback
        new_case("enable_hold", 4, 6);
        emit(addi_instr(1, 0, 10));         retires(1, 32'd10);
        emit(addi_instr(2, 1, 20));         retires(2, 32'd30);
        emit(store_instr(2, 0, 8));
        emit(load_instr(3, 0, 8));          retires(3, 32'd30);
        emit(branch_instr(1'b1, 3, 0, 12)); // bne to pc 28
        emit(addi_instr(4, 0, 1));
        emit(addi_instr(5, 0, 1));
        emit(reg_op(F_ADD, 6, 3, 1));       retires(6, 32'd40);
    endtask

    // One clock with the given enable, sampled once the inputs settle
    task automatic step(input logic en);
        @(negedge clock);
        enable = en;
        #1;
    endtask

    task automatic reset_pipeline();
        @(negedge clock);
        reset  = 1'b1;
        enable = 1'b0;
        repeat (8) @(negedge clock);
        reset = 1'b0;
    endtask

    task automatic load_program(input int c);
        int a;
        for (a = 0; a < `CPU_IMEM_DEPTH; a++) begin
            @(negedge clock);
            imem_write   = 1'b1;
            imem_address = IMEM_AW'(a);
            if (a < word_count[c]) begin
                imem_data = program_word[c][a];
            end else begin
                // Illegal opcode tagged with its own address
                imem_data = {IMEM_AW'(a), {(`CPU_XLEN - IMEM_AW){1'b0}}};
            end
        end
        @(negedge clock);
        imem_write = 1'b0;
    endtask

    task automatic run_case(input int c);
        int   seen;
        int   cycles;
        int   errors;
        int   i;
        logic hold;
        seen   = 0;
        cycles = 0;
        errors = 0;
        reset_pipeline();
        load_program(c);
        while (seen < retire_count[c] && cycles < WAIT_LIMIT) begin
            hold = (cycles >= hold_start[c]) && (cycles < hold_start[c] + hold_length[c]);
            step(!hold);
            cycles++;
            if (retire_valid) begin
                if (hold) begin
                    $display("%s: retire of x%0d appeared while enable was low",
                             case_name[c], retire_rd);
                    errors++;
                end else if (retire_rd !== expect_rd[c][seen] ||
                             retire_value !== expect_value[c][seen]) begin
                    $display("[FAIL] %s: retire %0d expected x%0d=%h, actual x%0d=%h",
                             case_name[c], seen, expect_rd[c][seen], expect_value[c][seen],
                             retire_rd, retire_value);
                    errors++;
                end
                checked++;
                seen++;
            end
        end
        if (seen < retire_count[c]) begin
            $display("%s: expected retire %0d of %0d never came within %0d cycles",
                     case_name[c], seen + 1, retire_count[c], WAIT_LIMIT);
            errors++;
        end
        for (i = 0; i < DRAIN; i++) begin  // Flushed or stray work must stay silent
            step(1'b1);
            if (retire_valid) begin
                $display("%s: unexpected extra retire of x%0d=%h",
                         case_name[c], retire_rd, retire_value);
                errors++;
            end
        end
        failures += errors;
        if (errors == 0) begin
            $display("%s: ok, %0d retires in order", case_name[c], seen);
        end else begin
            $display("%s: %0d errors", case_name[c], errors);
        end
    endtask

    initial begin
        reset        = 1'b1;
        enable       = 1'b0;
        imem_write   = 1'b0;
        imem_address = '0;
        imem_data    = '0;
        case_total   = 0;
        failures     = 0;
        checked      = 0;
        build_table();
        for (int c = 0; c < case_total; c++) begin
            run_case(c);
        end
        $display("%0d cases, %0d retires checked, %0d failures", case_total, checked, failures);
        if (failures == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== sim/tb_clock.sv ====
`default_nettype none

module tb_clock #(
    parameter int PERIOD = 100
) (
    output logic clock
);

    initial begin
        clock = 1'b0;
        forever begin
            #(PERIOD / 2) clock = ~clock;
        end
    end

endmodule

`default_nettype wire
